// ==== hw/param_finder_macros.svh ====
`ifndef PARAM_FINDER_MACROS_SVH
`define PARAM_FINDER_MACROS_SVH

////////////////////////////////////////////////////////////
// register file geometry
////////////////////////////////////////////////////////////

// entries per file, shared by both files
`define PF_RF_DEPTH 4096
`define PF_ADDR_W 12

////////////////////////////////////////////////////////////
// word and field widths
////////////////////////////////////////////////////////////

`define PF_INEX_W 32
`define PF_STATE_W 17
`define PF_PARAM_W 8
`define PF_POS_W 16

// byte lanes of the parameter word, i on top
`define PF_I_LSB 24
`define PF_Z_LSB 16
`define PF_K_LSB 8
`define PF_L_LSB 0

// state word, position above the finished bit
`define PF_POS_LSB 1
`define PF_FIN_BIT 0
`endif

// ==== hw/param_finder_pkg.sv ====
`default_nettype none

`include "param_finder_macros.svh"

package param_finder_pkg;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    // entry index into either register file
    typedef logic [`PF_ADDR_W-1:0] rf_addr_t;

    // {i, z, k, l}
    typedef logic [`PF_INEX_W-1:0] inex_word_t;

    // {position, finished}
    typedef logic [`PF_STATE_W-1:0] state_word_t;

    typedef logic [`PF_PARAM_W-1:0] param_byte_t;
    typedef logic [`PF_POS_W-1:0]   position_t;

    ////////////////////////////////////////////////////////////
    // control machine
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,  // waiting for start
        CTRL_CLEAR = 2'd1,  // rewind both read pointers
        CTRL_SCAN  = 2'd2,  // walking the entries
        CTRL_HOLD  = 2'd3   // result held until finish
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/regfile_inex_recur.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "param_finder_macros.svh"

module regfile_inex_recur (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // append write
    input  logic                         we_i,
    input  param_finder_pkg::inex_word_t w_data_i,
    // read pointer controls
    input  logic                         seq_re_i,
    input  logic                         ran_re_i,
    input  param_finder_pkg::rf_addr_t   ran_r_addr_i,
    // presented entry
    output param_finder_pkg::rf_addr_t   r_addr_o,
    output param_finder_pkg::inex_word_t r_data_o,
    output logic                         r_valid_o
);

    import param_finder_pkg::*;

    inex_word_t          mem_q [`PF_RF_DEPTH];
    inex_word_t          r_data_q;
    logic [`PF_ADDR_W:0] w_idx_q;      // msb set once the file is full
    logic [`PF_ADDR_W:0] rd_ptr_q;     // msb set when walked past the top
    logic [`PF_ADDR_W:0] rd_ptr_nxt;
    logic                wr_ok;

    assign wr_ok      = we_i && !w_idx_q[`PF_ADDR_W];  // drop writes when full
    assign rd_ptr_nxt = rd_ptr_q + 1'b1;

    ////////////////////////////////////////////////////////////
    // write index and read pointer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            w_idx_q  <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_ok) begin
                w_idx_q <= w_idx_q + 1'b1;
            end
            if (ran_re_i) begin
                rd_ptr_q <= {1'b0, ran_r_addr_i};
            end else if (seq_re_i) begin
                rd_ptr_q <= rd_ptr_nxt;
            end
        end
    end

    // storage, read data follows the strobe by one cycle
    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem_q[w_idx_q[`PF_ADDR_W-1:0]] <= w_data_i;
        end
        if (ran_re_i) begin
            r_data_q <= mem_q[ran_r_addr_i];
        end else if (seq_re_i) begin
            r_data_q <= mem_q[rd_ptr_nxt[`PF_ADDR_W-1:0]];
        end
    end

    assign r_addr_o  = rd_ptr_q[`PF_ADDR_W-1:0];
    assign r_data_o  = r_data_q;
    assign r_valid_o = (rd_ptr_q < w_idx_q);  // presented entry was appended

endmodule

`default_nettype wire

// ==== hw/regfile_state.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "param_finder_macros.svh"

module regfile_state (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // append write
    input  logic                          we_i,
    input  param_finder_pkg::state_word_t w_data_i,
    // read pointer controls
    input  logic                          seq_re_i,
    input  logic                          ran_re_i,
    input  param_finder_pkg::rf_addr_t    ran_r_addr_i,
    // presented entry
    output param_finder_pkg::state_word_t r_data_o
);

    import param_finder_pkg::*;

    state_word_t         mem_q [`PF_RF_DEPTH];
    state_word_t         r_data_q;
    logic [`PF_ADDR_W:0] w_idx_q;     // msb set once the file is full
    rf_addr_t            rd_ptr_q;    // tracks the parameter file pointer
    rf_addr_t            rd_ptr_nxt;
    logic                wr_ok;

    assign wr_ok      = we_i && !w_idx_q[`PF_ADDR_W];
    assign rd_ptr_nxt = rd_ptr_q + 1'b1;

    ////////////////////////////////////////////////////////////
    // write index and read pointer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            w_idx_q  <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_ok) begin
                w_idx_q <= w_idx_q + 1'b1;
            end
            if (ran_re_i) begin
                rd_ptr_q <= ran_r_addr_i;
            end else if (seq_re_i) begin
                rd_ptr_q <= rd_ptr_nxt;
            end
        end
    end

    // storage and registered read port
    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem_q[w_idx_q[`PF_ADDR_W-1:0]] <= w_data_i;
        end
        if (ran_re_i) begin
            r_data_q <= mem_q[ran_r_addr_i];
        end else if (seq_re_i) begin
            r_data_q <= mem_q[rd_ptr_nxt];
        end
    end

    assign r_data_o = r_data_q;

endmodule

`default_nettype wire

// ==== hw/get_param.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "param_finder_macros.svh"

module get_param (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  param_finder_pkg::ctrl_state_t ctrl_state_i,
    // parameter file
    output logic                          seq_re_inex_o,
    output logic                          ran_re_inex_o,
    output param_finder_pkg::rf_addr_t    ran_addr_inex_o,
    input  param_finder_pkg::rf_addr_t    inex_addr_i,
    input  param_finder_pkg::inex_word_t  inex_data_i,
    input  logic                          inex_valid_i,
    // state file
    output logic                          seq_re_state_o,
    output logic                          ran_re_state_o,
    output param_finder_pkg::rf_addr_t    ran_addr_state_o,
    input  param_finder_pkg::state_word_t state_data_i,
    // held result
    output param_finder_pkg::param_byte_t i_o,
    output param_finder_pkg::param_byte_t z_o,
    output param_finder_pkg::param_byte_t k_o,
    output param_finder_pkg::param_byte_t l_o,
    output param_finder_pkg::rf_addr_t    addr_o,
    output param_finder_pkg::position_t   position_o,
    output logic                          found_o,
    output logic                          done_o,
    // back to the control machine
    output logic                          scan_hit_o,
    output logic                          scan_end_o
);

    import param_finder_pkg::*;

    logic        scan_go;
    logic        hit;
    logic        at_end;
    logic        ran_re;
    logic        seq_re;
    logic        found_q;
    logic        done_q;
    param_byte_t i_q, z_q, k_q, l_q;
    rf_addr_t    addr_q;
    position_t   pos_q;

    ////////////////////////////////////////////////////////////
    // scan decisions on the presented word pair
    ////////////////////////////////////////////////////////////

    // stop looking once done is up, the machine leaves scan next edge
    assign scan_go = (ctrl_state_i == CTRL_SCAN) && !done_q;
    assign at_end  = scan_go && !inex_valid_i;
    assign hit     = scan_go && inex_valid_i && !state_data_i[`PF_FIN_BIT];
    assign seq_re  = scan_go && inex_valid_i && state_data_i[`PF_FIN_BIT];
    assign ran_re  = (ctrl_state_i == CTRL_CLEAR);  // rewind both files

    assign ran_re_inex_o    = ran_re;
    assign ran_re_state_o   = ran_re;
    assign ran_addr_inex_o  = '0;       // every scan starts at entry 0
    assign ran_addr_state_o = '0;
    assign seq_re_inex_o    = seq_re;   // pointers move in lockstep
    assign seq_re_state_o   = seq_re;

    // control flags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            found_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= hit || at_end;   // one cycle, next edge is hold
            if (ctrl_state_i == CTRL_IDLE) begin
                found_q <= 1'b0;
            end else if (hit) begin
                found_q <= 1'b1;
            end else if (at_end) begin
                found_q <= 1'b0;
            end
        end
    end

    // capture the fields of the hit
    always_ff @(posedge clk_i) begin
        if (hit) begin
            i_q    <= inex_data_i[`PF_I_LSB +: `PF_PARAM_W];
            z_q    <= inex_data_i[`PF_Z_LSB +: `PF_PARAM_W];
            k_q    <= inex_data_i[`PF_K_LSB +: `PF_PARAM_W];
            l_q    <= inex_data_i[`PF_L_LSB +: `PF_PARAM_W];
            addr_q <= inex_addr_i;
            pos_q  <= state_data_i[`PF_POS_LSB +: `PF_POS_W];
        end
    end

    assign i_o        = i_q;
    assign z_o        = z_q;
    assign k_o        = k_q;
    assign l_o        = l_q;
    assign addr_o     = addr_q;
    assign position_o = pos_q;
    assign found_o    = found_q;
    assign done_o     = done_q;
    assign scan_hit_o = done_q && found_q;
    assign scan_end_o = done_q && !found_q;

endmodule

`default_nettype wire

// ==== hw/state_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module state_control (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          start_i,
    input  logic                          finish_i,
    input  logic                          scan_hit_i,
    input  logic                          scan_end_i,
    output param_finder_pkg::ctrl_state_t state_o,
    output logic                          busy_o
);

    import param_finder_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (start_i) begin
                    state_d = CTRL_CLEAR;  // start only counts here
                end
            end
            CTRL_CLEAR: begin
                state_d = CTRL_SCAN;       // single cycle rewind
            end
            CTRL_SCAN: begin
                if (scan_hit_i || scan_end_i) begin
                    state_d = CTRL_HOLD;
                end
            end
            CTRL_HOLD: begin
                if (finish_i) begin
                    state_d = CTRL_IDLE;
                end
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // busy through rewind and scan, which includes the done cycle
    assign busy_o = (state_q == CTRL_CLEAR) || (state_q == CTRL_SCAN);

endmodule

`default_nettype wire

// ==== hw/param_finder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_finder_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // host append writes
    input  logic                          we_inex_i,
    input  param_finder_pkg::inex_word_t  w_data_inex_i,
    input  logic                          we_state_i,
    input  param_finder_pkg::state_word_t w_data_state_i,
    // host control pulses
    input  logic                          start_i,
    input  logic                          finish_i,
    // result
    output param_finder_pkg::param_byte_t i_o,
    output param_finder_pkg::param_byte_t z_o,
    output param_finder_pkg::param_byte_t k_o,
    output param_finder_pkg::param_byte_t l_o,
    output param_finder_pkg::rf_addr_t    addr_o,
    output param_finder_pkg::position_t   position_o,
    output logic                          found_o,
    output logic                          done_o,
    output logic                          busy_o
);

    import param_finder_pkg::*;

    ctrl_state_t ctrl_state;
    logic        scan_hit;
    logic        scan_end;

    // parameter file read side
    logic        seq_re_inex, ran_re_inex;
    rf_addr_t    ran_addr_inex;
    rf_addr_t    inex_addr;
    inex_word_t  inex_data;
    logic        inex_valid;

    // state file read side
    logic        seq_re_state, ran_re_state;
    rf_addr_t    ran_addr_state;
    state_word_t state_data;

    ////////////////////////////////////////////////////////////
    // register files side by side
    ////////////////////////////////////////////////////////////
    regfile_inex_recur u_rf_inex (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .we_i        (we_inex_i),
        .w_data_i    (w_data_inex_i),
        .seq_re_i    (seq_re_inex),
        .ran_re_i    (ran_re_inex),
        .ran_r_addr_i(ran_addr_inex),
        .r_addr_o    (inex_addr),
        .r_data_o    (inex_data),
        .r_valid_o   (inex_valid)
    );

    regfile_state u_rf_state (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .we_i        (we_state_i),
        .w_data_i    (w_data_state_i),
        .seq_re_i    (seq_re_state),
        .ran_re_i    (ran_re_state),
        .ran_r_addr_i(ran_addr_state),
        .r_data_o    (state_data)
    );

    ////////////////////////////////////////////////////////////
    // scan engine and its sequencer
    ////////////////////////////////////////////////////////////
    get_param u_get_param (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ctrl_state_i    (ctrl_state),
        .seq_re_inex_o   (seq_re_inex),
        .ran_re_inex_o   (ran_re_inex),
        .ran_addr_inex_o (ran_addr_inex),
        .inex_addr_i     (inex_addr),
        .inex_data_i     (inex_data),
        .inex_valid_i    (inex_valid),
        .seq_re_state_o  (seq_re_state),
        .ran_re_state_o  (ran_re_state),
        .ran_addr_state_o(ran_addr_state),
        .state_data_i    (state_data),
        .i_o             (i_o),
        .z_o             (z_o),
        .k_o             (k_o),
        .l_o             (l_o),
        .addr_o          (addr_o),
        .position_o      (position_o),
        .found_o         (found_o),
        .done_o          (done_o),
        .scan_hit_o      (scan_hit),
        .scan_end_o      (scan_end)
    );

    state_control u_state_control (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (start_i),
        .finish_i  (finish_i),
        .scan_hit_i(scan_hit),
        .scan_end_i(scan_end),
        .state_o   (ctrl_state),
        .busy_o    (busy_o)
    );

endmodule

`default_nettype wire

// ==== tb/param_finder_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_finder_checker (
    input logic                          clk_i,
    input logic                          rst_n_i,
    input param_finder_pkg::ctrl_state_t ctrl_state_i,
    input logic                          we_inex_i,
    input logic                          we_state_i,
    input logic                          found_i,
    input logic                          done_i,
    input logic                          busy_i
);

    import param_finder_pkg::*;

    int unsigned fail_cnt = 0;  // failed assertions so far

    ////////////////////////////////////////////////////////////
    // scan completion
    ////////////////////////////////////////////////////////////
    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done_o held longer than one cycle");
        end

    a_busy_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |-> busy_i ##1 !busy_i)
        else begin
            fail_cnt++;
            $error("busy_o did not fall right after done_o");
        end

    // result stays put until finish
    a_found_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ctrl_state_i == CTRL_HOLD) ##1 (ctrl_state_i == CTRL_HOLD) |-> $stable(found_i))
        else begin
            fail_cnt++;
            $error("found_o changed during hold");
        end

    a_no_write_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_i |-> !(we_inex_i || we_state_i))
        else begin
            fail_cnt++;
            $error("host write while busy_o is high");
        end

endmodule

bind param_finder_top param_finder_checker u_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctrl_state_i(ctrl_state),
    .we_inex_i   (we_inex_i),
    .we_state_i  (we_state_i),
    .found_i     (found_o),
    .done_i      (done_o),
    .busy_i      (busy_o)
);

`default_nettype wire

// ==== tb/tb_param_finder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_param_finder;

    import param_finder_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int SCEN_MARGIN  = 100;  // cycles per scenario on top of its writes
    localparam int NUM_SCEN     = 8;

    typedef struct packed {
        logic [7:0]  n_new;       // entries appended
        logic [15:0] unfin_mask;  // new entry j unfinished when bit j is set
        logic        rebuild;     // reset before writing
        logic        dbl_start;   // start held high through the scan
    } scen_t;

    localparam scen_t SCEN [NUM_SCEN] = '{
        '{8'd4,  16'h0001, 1'b1, 1'b1},   // hit at entry 0
        '{8'd0,  16'h0000, 1'b0, 1'b0},   // rescan gives the same result
        '{8'd8,  16'h00a0, 1'b1, 1'b0},   // first unfinished at 5
        '{8'd6,  16'h0000, 1'b1, 1'b0},   // all finished
        '{8'd3,  16'h0004, 1'b0, 1'b0},   // hit at 8 past the old end
        '{8'd0,  16'h0000, 1'b1, 1'b0},   // empty files
        '{8'd10, 16'h0200, 1'b0, 1'b1},   // hit at 9
        '{8'd0,  16'h0000, 1'b0, 1'b0}
    };

    logic        clk_i;
    logic        rst_n_i;
    logic        we_inex_i;
    inex_word_t  w_data_inex_i;
    logic        we_state_i;
    state_word_t w_data_state_i;
    logic        start_i;
    logic        finish_i;
    param_byte_t i_o, z_o, k_o, l_o;
    rf_addr_t    addr_o;
    position_t   position_o;
    logic        found_o, done_o, busy_o;

    integer      seed = 32'hfe6a9176;
    int unsigned errors;
    logic        abort;
    inex_word_t  model_inex [$];   // what the host has appended so far
    state_word_t model_state [$];

    param_finder_top u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .we_inex_i     (we_inex_i),
        .w_data_inex_i (w_data_inex_i),
        .we_state_i    (we_state_i),
        .w_data_state_i(w_data_state_i),
        .start_i       (start_i),
        .finish_i      (finish_i),
        .i_o           (i_o),
        .z_o           (z_o),
        .k_o           (k_o),
        .l_o           (l_o),
        .addr_o        (addr_o),
        .position_o    (position_o),
        .found_o       (found_o),
        .done_o        (done_o),
        .busy_o        (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic longint watchdog_cycles();
        longint total;
        total = 0;
        for (int s = 0; s < NUM_SCEN; s++) begin
            total += SCEN[s].n_new + SCEN_MARGIN;
        end
        return total;
    endfunction

    initial begin
        #(watchdog_cycles() * CLK_PERIOD);
        $display("error: watchdog expired before all scenarios completed");
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input string what, input param_byte_t got, input param_byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_loc(input position_t got_pos, input position_t exp_pos,
                             input rf_addr_t got_addr, input rf_addr_t exp_addr);
        if (got_pos !== exp_pos) begin
            errors++;
            $display("mismatch at %0t: position_o is %04h, expected %04h",
                     $time, got_pos, exp_pos);
        end
        if (got_addr !== exp_addr) begin
            errors++;
            $display("mismatch at %0t: addr_o is %0d, expected %0d", $time, got_addr, exp_addr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////
    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
    endtask

    task automatic append_entry(input inex_word_t w, input state_word_t st);
        we_inex_i      = 1'b1;
        w_data_inex_i  = w;
        we_state_i     = 1'b1;
        w_data_state_i = st;
        @(posedge clk_i);
        #1;
        we_inex_i  = 1'b0;
        we_state_i = 1'b0;
        model_inex.push_back(w);
        model_state.push_back(st);
    endtask

    task automatic pulse_start(input logic dbl);
        start_i = 1'b1;
        @(posedge clk_i);
        #1;
        check_flag("busy_o after start", busy_o, 1'b1);
        start_i = dbl;  // stays up through clear, scan and the done cycle
    endtask

    task automatic pulse_finish();
        finish_i = 1'b1;
        @(posedge clk_i);
        #1;
        finish_i = 1'b0;
    endtask

    task automatic wait_done(input int bound, output logic seen);
        int cyc;
        seen = 1'b0;
        for (cyc = 0; cyc < bound && !seen; cyc++) begin
            @(posedge clk_i);
            #1;
            seen = done_o;
        end
    endtask

    // index of the first appended entry with a clear finished bit or -1
    function automatic int first_unfinished();
        int idx;
        idx = -1;
        for (int n = 0; n < model_state.size() && idx < 0; n++) begin
            if (model_state[n][0] == 1'b0) begin
                idx = n;
            end
        end
        return idx;
    endfunction

    task automatic check_result(input int idx);
        inex_word_t  w;
        state_word_t st;
        w  = model_inex[idx];
        st = model_state[idx];
        check_byte("i_o", i_o, w[31:24]);
        check_byte("z_o", z_o, w[23:16]);
        check_byte("k_o", k_o, w[15:8]);
        check_byte("l_o", l_o, w[7:0]);
        check_loc(position_o, st[16:1], addr_o, rf_addr_t'(idx));
    endtask

    ////////////////////////////////////////////////////////////
    // scenario loop
    ////////////////////////////////////////////////////////////
    initial begin
        int          s;
        int          j;
        int          exp_idx;
        logic        seen;
        inex_word_t  w;
        state_word_t st;
        errors         = 0;
        abort          = 1'b0;
        rst_n_i        = 1'b0;
        we_inex_i      = 1'b0;
        w_data_inex_i  = '0;
        we_state_i     = 1'b0;
        w_data_state_i = '0;
        start_i        = 1'b0;
        finish_i       = 1'b0;
        apply_reset();
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("found_o after reset", found_o, 1'b0);
        check_flag("done_o after reset", done_o, 1'b0);
        for (s = 0; s < NUM_SCEN && !abort; s++) begin
            if (SCEN[s].rebuild) begin
                apply_reset();
                model_inex.delete();
                model_state.delete();
            end
            for (j = 0; j < SCEN[s].n_new; j++) begin
                w  = $random(seed);
                st = {position_t'($random(seed)), !SCEN[s].unfin_mask[j]};
                append_entry(w, st);
            end
            exp_idx = first_unfinished();
            pulse_start(SCEN[s].dbl_start);
            wait_done(model_inex.size() + 8, seen);
            if (!seen) begin
                $display("error: done_o never arrived in scenario %0d", s);
                errors++;
                abort = 1'b1;
            end else begin
                check_flag("found_o at done", found_o, exp_idx >= 0);
                if (exp_idx >= 0) begin
                    check_result(exp_idx);
                end
                @(posedge clk_i);  // now in hold
                #1;
                start_i = 1'b0;
                check_flag("busy_o in hold", busy_o, 1'b0);
                check_flag("found_o in hold", found_o, exp_idx >= 0);
                pulse_finish();
            end
        end
        $display("errors: %0d from checks, %0d from assertions",
                 errors, u_dut.u_checker.fail_cnt);
        if (errors == 0 && u_dut.u_checker.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/param_finder_pkg.sv
hw/regfile_inex_recur.sv
hw/regfile_state.sv
hw/get_param.sv
hw/state_control.sv
hw/param_finder_top.sv
tb/param_finder_checker.sv
tb/tb_param_finder.sv

// ==== Bender.yml ====
package:
  name: param_finder

export_include_dirs:
  - hw

sources:
  - files:
      - hw/param_finder_pkg.sv
      - hw/regfile_inex_recur.sv
      - hw/regfile_state.sv
      - hw/get_param.sv
      - hw/state_control.sv
      - hw/param_finder_top.sv
  - target: test
    files:
      - tb/param_finder_checker.sv
      - tb/tb_param_finder.sv
